// File: Bender.yml
package:
  name: block_matmul

sources:
  - matmul_pkg.sv
  - block_stream_if.sv
  - ram_1w1r.sv
  - r2b_converter_v.sv
  - r2b_converter_h.sv
  - block_mac.sv
  - block_matmul_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_block_matmul.sv

// File: block_mac.sv
`timescale 1ns/100ps
// Block multiply-accumulate unit
// Multiplies paired A and B blocks, sums over k and emits rounded,
// saturated Q8.8 C blocks on a valid/ready output
module block_mac (
    input  logic               clk,
    input  logic               rst_n,
    block_stream_if.sink       a_in,
    block_stream_if.sink       b_in,
    output logic               c_valid,
    input  logic               c_ready,
    output matmul_pkg::block_t c_block,
    output logic               c_last
);
    import matmul_pkg::*;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    acc_t   acc      [BLOCK_SIZE*BLOCK_SIZE];
    acc_t   acc_next [BLOCK_SIZE*BLOCK_SIZE];
    block_t c_next;
    logic   out_stall;
    logic   pair_xfer;

    function automatic elem_t elem_at(block_t blk, int r, int c);
        return elem_t'(blk[(r*BLOCK_SIZE+c)*DATA_WIDTH +: DATA_WIDTH]);
    endfunction

    // Arithmetic shift rounds toward negative infinity
    function automatic elem_t round_sat(acc_t value);
        acc_t  shifted;
        elem_t result;
        shifted = value >>> FRAC_WIDTH;
        if (shifted > acc_t'(ELEM_MAX)) begin
            result = ELEM_MAX;
        end else if (shifted < acc_t'(ELEM_MIN)) begin
            result = ELEM_MIN;
        end else begin
            result = elem_t'(shifted);
        end
        return result;
    endfunction

    // Held output blocks both input streams
    assign out_stall      = c_valid && !c_ready;
    assign pair_xfer      = a_in.blk_valid && b_in.blk_valid && !out_stall;
    assign a_in.blk_ready = pair_xfer;
    assign b_in.blk_ready = pair_xfer;

    always_comb begin
        acc_t dot;
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                dot = '0;
                for (int m = 0; m < BLOCK_SIZE; m++) begin
                    dot = dot + acc_t'(elem_at(a_in.blk, r, m)) *
                                acc_t'(elem_at(b_in.blk, m, c));
                end
                // blk_first starts a new C block
                acc_next[r*BLOCK_SIZE+c] = a_in.blk_first ? dot : acc[r*BLOCK_SIZE+c] + dot;
                c_next[(r*BLOCK_SIZE+c)*DATA_WIDTH +: DATA_WIDTH] =
                    round_sat(acc_next[r*BLOCK_SIZE+c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_xfer) begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_valid <= 1'b0;
            c_last  <= 1'b0;
        end else if (pair_xfer && !a_in.blk_first) begin
            c_valid <= 1'b1;
            c_last  <= a_in.blk_last && b_in.blk_last;
        end else if (c_ready) begin
            c_valid <= 1'b0;
            c_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pair_xfer && !a_in.blk_first) begin
            c_block <= c_next;
        end
    end

endmodule

// File: block_matmul_top.sv
`timescale 1ns/100ps
// Top level of the 4x4 Q8.8 block matrix multiplier
// Converters for A and B feed the block MAC, busy spans one run
module block_matmul_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               a_row_valid,
    input  matmul_pkg::row_t   a_row,
    input  logic               b_row_valid,
    input  matmul_pkg::row_t   b_row,
    input  logic               c_ready,
    output logic               c_valid,
    output matmul_pkg::block_t c_block,
    output logic               c_last,
    output logic               busy
);

    logic start_ok;

    block_stream_if a_blk ();
    block_stream_if b_blk ();

    // Start pulses during a run are dropped
    assign start_ok = start && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start_ok) begin
            busy <= 1'b1;
        end else if (c_valid && c_ready && c_last) begin
            busy <= 1'b0;
        end
    end

    r2b_converter_v u_conv_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_ok),
        .row_valid (a_row_valid),
        .row       (a_row),
        .blk_out   (a_blk.source),
        .done      ()
    );

    r2b_converter_h u_conv_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_ok),
        .row_valid (b_row_valid),
        .row       (b_row),
        .blk_out   (b_blk.source),
        .done      ()
    );

    block_mac u_mac (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_in    (a_blk.sink),
        .b_in    (b_blk.sink),
        .c_valid (c_valid),
        .c_ready (c_ready),
        .c_block (c_block),
        .c_last  (c_last)
    );

endmodule

// File: block_stream_if.sv
`timescale 1ns/100ps
// Block stream between a row-to-block converter and the block MAC
// valid/ready handshake, flags held with the block until it transfers
interface block_stream_if;
    import matmul_pkg::*;

    block_t blk;
    logic   blk_valid;
    // First k of a C block
    logic   blk_first;
    // Final block of the whole product
    logic   blk_last;
    logic   blk_ready;

    modport source (
        output blk,
        output blk_valid,
        output blk_first,
        output blk_last,
        input  blk_ready
    );

    modport sink (
        input  blk,
        input  blk_valid,
        input  blk_first,
        input  blk_last,
        output blk_ready
    );

endinterface

// File: filelist.f
matmul_pkg.sv
block_stream_if.sv
ram_1w1r.sv
r2b_converter_v.sv
r2b_converter_h.sv
block_mac.sv
block_matmul_top.sv
tb_clock_gen.sv
tb_block_matmul.sv

// File: matmul_pkg.sv
// Sizes, Q8.8 format limits and data types of the block matrix multiplier
// Converter state encoding and the helper that cuts a 2x2 block out of two rows
package matmul_pkg;

    localparam int DATA_WIDTH     = 16;
    localparam int FRAC_WIDTH     = 8;
    localparam int BLOCK_SIZE     = 2;
    localparam int MAT_DIM        = 4;
    localparam int BLOCKS_PER_DIM = MAT_DIM / BLOCK_SIZE;
    localparam int ACC_WIDTH      = 40;

    localparam int ROW_WIDTH      = DATA_WIDTH * MAT_DIM;
    localparam int BLOCK_WIDTH    = DATA_WIDTH * BLOCK_SIZE * BLOCK_SIZE;
    localparam int ROW_ADDR_WIDTH = $clog2(MAT_DIM);
    localparam int BIDX_WIDTH     = $clog2(BLOCKS_PER_DIM);

    typedef logic signed [DATA_WIDTH-1:0] elem_t;
    typedef logic [ROW_WIDTH-1:0]         row_t;
    typedef logic [BLOCK_WIDTH-1:0]       block_t;
    typedef logic [BIDX_WIDTH-1:0]        bidx_t;

    // Q8.8 saturation limits
    localparam elem_t ELEM_MAX = elem_t'(2**(DATA_WIDTH-1) - 1);
    localparam elem_t ELEM_MIN = elem_t'(-(2**(DATA_WIDTH-1)));

    localparam bidx_t                     LAST_BIDX = bidx_t'(BLOCKS_PER_DIM - 1);
    localparam logic [ROW_ADDR_WIDTH-1:0] LAST_ROW  = ROW_ADDR_WIDTH'(MAT_DIM - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,
        ST_SLICE_RD,
        ST_OUTPUT,
        ST_DONE
    } conv_state_t;

    // Element (r,c) of the block comes from row r of the slice, column col*2+c
    function automatic block_t cut_block(row_t row_lo, row_t row_hi, bidx_t col);
        block_t blk;
        row_t   src;
        for (int r = 0; r < BLOCK_SIZE; r++) begin
            src = (r == 0) ? row_lo : row_hi;
            for (int c = 0; c < BLOCK_SIZE; c++) begin
                blk[(r*BLOCK_SIZE+c)*DATA_WIDTH +: DATA_WIDTH] =
                    src[(col*BLOCK_SIZE+c)*DATA_WIDTH +: DATA_WIDTH];
            end
        end
        return blk;
    endfunction

endpackage

// File: r2b_converter_h.sv
`timescale 1ns/100ps
// Horizontal row-to-block converter for matrix B
// Stores the four rows of B and for each pair (i,j,k) reads rows 2k, 2k+1
// and cuts out column pair j, giving B(k,j)
module r2b_converter_h (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             row_valid,
    input  matmul_pkg::row_t row,
    block_stream_if.source   blk_out,
    output logic             done
);
    import matmul_pkg::*;

    conv_state_t state;

    logic                      wr_en;
    logic [ROW_ADDR_WIDTH-1:0] wr_addr;
    row_t                      wr_row;
    logic [ROW_ADDR_WIDTH-1:0] fill_cnt;

    logic [ROW_ADDR_WIDTH-1:0] rd_addr;
    row_t                      rd_row;
    logic [1:0]                rd_phase;
    row_t                      slice_lo;
    row_t                      slice_hi;

    // Block counter {i, j, k}, k least significant
    logic [3*BIDX_WIDTH-1:0]   blk_cnt;
    bidx_t                     bj;
    bidx_t                     bk;

    logic   xfer;
    logic   slot_free;
    logic   from_dout;
    logic   present;
    block_t next_blk;

    assign bj = blk_cnt[2*BIDX_WIDTH-1 -: BIDX_WIDTH];
    assign bk = blk_cnt[BIDX_WIDTH-1:0];

    // Rows 2k and 2k+1
    assign rd_addr = {bk, rd_phase[0]};

    assign xfer      = blk_out.blk_valid && blk_out.blk_ready;
    assign slot_free = !blk_out.blk_valid || xfer;
    assign from_dout = (state == ST_SLICE_RD) && (rd_phase == 2'd2);
    assign present   = slot_free && (from_dout || (state == ST_OUTPUT));
    assign next_blk  = cut_block(slice_lo, from_dout ? rd_row : slice_hi, bj);
    assign done      = (state == ST_DONE) && !blk_out.blk_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= (state == ST_FILL) && row_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= fill_cnt;
        wr_row  <= row;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            fill_cnt <= '0;
            rd_phase <= 2'd0;
            blk_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state    <= ST_FILL;
                        fill_cnt <= '0;
                        rd_phase <= 2'd0;
                        blk_cnt  <= '0;
                    end
                end
                ST_FILL: begin
                    if (row_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    if (wr_en && (wr_addr == LAST_ROW)) begin
                        state <= ST_SLICE_RD;
                    end
                end
                ST_SLICE_RD: begin
                    rd_phase <= rd_phase + 2'd1;
                    if (rd_phase == 2'd1) begin
                        slice_lo <= rd_row;
                    end
                    if (rd_phase == 2'd2) begin
                        slice_hi <= rd_row;
                        rd_phase <= 2'd0;
                        // Output still occupied, keep the slice pending
                        state    <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    state <= ST_OUTPUT;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // Every block has its own slice read
            if (present) begin
                blk_cnt <= blk_cnt + 1'b1;
                state   <= (blk_cnt == '1) ? ST_DONE : ST_SLICE_RD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_out.blk_valid <= 1'b0;
            blk_out.blk_first <= 1'b0;
            blk_out.blk_last  <= 1'b0;
        end else if (present) begin
            blk_out.blk_valid <= 1'b1;
            blk_out.blk_first <= (bk == '0);
            blk_out.blk_last  <= (blk_cnt == '1);
        end else if (xfer) begin
            blk_out.blk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (present) begin
            blk_out.blk <= next_blk;
        end
    end

    ram_1w1r u_ram (
        .clk        (clk),
        .we         (wr_en),
        .write_addr (wr_addr),
        .read_addr  (rd_addr),
        .din        (wr_row),
        .dout       (rd_row)
    );

endmodule

// File: r2b_converter_v.sv
`timescale 1ns/100ps
// Vertical row-to-block converter for matrix A
// Stores the four rows of A, reads block row i as a two-row slice and
// issues A(i,0), A(i,1) from it, once for every block column j of C
module r2b_converter_v (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  logic             row_valid,
    input  matmul_pkg::row_t row,
    block_stream_if.source   blk_out,
    output logic             done
);
    import matmul_pkg::*;

    conv_state_t state;

    // Write stage, one cycle behind row_valid
    logic                      wr_en;
    logic [ROW_ADDR_WIDTH-1:0] wr_addr;
    row_t                      wr_row;
    logic [ROW_ADDR_WIDTH-1:0] fill_cnt;

    logic [ROW_ADDR_WIDTH-1:0] rd_addr;
    row_t                      rd_row;
    logic [1:0]                rd_phase;
    row_t                      slice_lo;
    row_t                      slice_hi;

    // Block counter {i, j, k}, k least significant
    logic [3*BIDX_WIDTH-1:0]   blk_cnt;
    bidx_t                     bi;
    bidx_t                     bk;

    logic   xfer;
    logic   slot_free;
    logic   from_dout;
    logic   present;
    block_t next_blk;

    assign bi = blk_cnt[3*BIDX_WIDTH-1 -: BIDX_WIDTH];
    assign bk = blk_cnt[BIDX_WIDTH-1:0];

    // Rows 2i and 2i+1
    assign rd_addr = {bi, rd_phase[0]};

    assign xfer      = blk_out.blk_valid && blk_out.blk_ready;
    assign slot_free = !blk_out.blk_valid || xfer;
    // Second slice row is still on the RAM output
    assign from_dout = (state == ST_SLICE_RD) && (rd_phase == 2'd2);
    assign present   = slot_free && (from_dout || (state == ST_OUTPUT));
    assign next_blk  = cut_block(slice_lo, from_dout ? rd_row : slice_hi, bk);
    assign done      = (state == ST_DONE) && !blk_out.blk_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= (state == ST_FILL) && row_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= fill_cnt;
        wr_row  <= row;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            fill_cnt <= '0;
            rd_phase <= 2'd0;
            blk_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state    <= ST_FILL;
                        fill_cnt <= '0;
                        rd_phase <= 2'd0;
                        blk_cnt  <= '0;
                    end
                end
                ST_FILL: begin
                    if (row_valid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                    // Fourth row lands in the RAM at this edge
                    if (wr_en && (wr_addr == LAST_ROW)) begin
                        state <= ST_SLICE_RD;
                    end
                end
                ST_SLICE_RD: begin
                    rd_phase <= rd_phase + 2'd1;
                    if (rd_phase == 2'd1) begin
                        slice_lo <= rd_row;
                    end
                    if (rd_phase == 2'd2) begin
                        slice_hi <= rd_row;
                        rd_phase <= 2'd0;
                        state    <= ST_OUTPUT;
                    end
                end
                ST_OUTPUT: begin
                    state <= ST_OUTPUT;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase

            // Slice is used up after k = 1, then the next slice is read
            if (present) begin
                blk_cnt <= blk_cnt + 1'b1;
                if (blk_cnt == '1) begin
                    state <= ST_DONE;
                end else if (bk == LAST_BIDX) begin
                    state <= ST_SLICE_RD;
                end else begin
                    state <= ST_OUTPUT;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_out.blk_valid <= 1'b0;
            blk_out.blk_first <= 1'b0;
            blk_out.blk_last  <= 1'b0;
        end else if (present) begin
            blk_out.blk_valid <= 1'b1;
            blk_out.blk_first <= (bk == '0);
            blk_out.blk_last  <= (blk_cnt == '1);
        end else if (xfer) begin
            blk_out.blk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (present) begin
            blk_out.blk <= next_blk;
        end
    end

    ram_1w1r u_ram (
        .clk        (clk),
        .we         (wr_en),
        .write_addr (wr_addr),
        .read_addr  (rd_addr),
        .din        (wr_row),
        .dout       (rd_row)
    );

endmodule

// File: ram_1w1r.sv
`timescale 1ns/100ps
// Row store with one write port and one registered read port
// One matrix row per word
module ram_1w1r (
    input  logic                                  clk,
    input  logic                                  we,
    input  logic [matmul_pkg::ROW_ADDR_WIDTH-1:0] write_addr,
    input  logic [matmul_pkg::ROW_ADDR_WIDTH-1:0] read_addr,
    input  matmul_pkg::row_t                      din,
    output matmul_pkg::row_t                      dout
);
    import matmul_pkg::*;

    row_t mem [MAT_DIM];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Read data is valid one cycle after the address
    always_ff @(posedge clk) begin
        dout <= mem[read_addr];
    end

endmodule

// File: tb_block_matmul.sv
`timescale 1ns/100ps
// Testbench for the block matrix multiplier
// Row stimulus, reference model with expected C block queue,
// concurrent checks on the C stream, error counts and timeout
module tb_block_matmul;
    import matmul_pkg::*;

    localparam int RUN_CYCLES  = 150;
    localparam int MAX_RUNS    = 8;
    localparam int CYCLE_LIMIT = MAX_RUNS * RUN_CYCLES;

    logic   clk;
    logic   rst_n;
    logic   start;
    logic   a_row_valid;
    row_t   a_row;
    logic   b_row_valid;
    row_t   b_row;
    logic   c_ready;
    logic   c_valid;
    block_t c_block;
    logic   c_last;
    logic   busy;

    elem_t  a_mat [MAT_DIM][MAT_DIM];
    elem_t  b_mat [MAT_DIM][MAT_DIM];
    block_t exp_q [$];
    bit     last_q [$];
    block_t exp_head;
    bit     exp_head_last;
    bit     exp_avail;
    bit     started;
    int     stall_pct;
    int     value_errors;
    int     other_errors;
    int     blocks_checked;
    int     cycle_cnt;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    block_matmul_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .a_row_valid (a_row_valid),
        .a_row       (a_row),
        .b_row_valid (b_row_valid),
        .b_row       (b_row),
        .c_ready     (c_ready),
        .c_valid     (c_valid),
        .c_block     (c_block),
        .c_last      (c_last),
        .busy        (busy)
    );

    task automatic report_and_finish();
        $display("C blocks checked: %0d, value errors: %0d, other errors: %0d",
                 blocks_checked, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Next falling edge with a new random c_ready under back-pressure
    task automatic next_cycle();
        @(negedge clk);
        c_ready = (stall_pct == 0) || (($urandom % 100) >= stall_pct);
    endtask

    task automatic refresh_head();
        exp_avail = (exp_q.size() != 0);
        if (exp_avail) begin
            exp_head      = exp_q[0];
            exp_head_last = last_q[0];
        end
    endtask

    task automatic fill_matrix(input bit is_a, input int range);
        int val;
        for (int r = 0; r < MAT_DIM; r++) begin
            for (int c = 0; c < MAT_DIM; c++) begin
                val = int'($urandom % (2 * range + 1)) - range;
                if (is_a) begin
                    a_mat[r][c] = elem_t'(val);
                end else begin
                    b_mat[r][c] = elem_t'(val);
                end
            end
        end
    endtask

    // 1.0 in Q8.8 on the diagonal
    task automatic set_identity_a();
        for (int r = 0; r < MAT_DIM; r++) begin
            for (int c = 0; c < MAT_DIM; c++) begin
                a_mat[r][c] = (r == c) ? elem_t'(256) : elem_t'(0);
            end
        end
    endtask

    // Top half of A and all of B near +-127.0 so the upper C blocks overflow Q8.8
    task automatic set_large_operands();
        fill_matrix(1'b1, 512);
        for (int r = 0; r < MAT_DIM; r++) begin
            for (int c = 0; c < MAT_DIM; c++) begin
                if (r < 2) begin
                    a_mat[r][c] = elem_t'(32512);
                end
                b_mat[r][c] = (c < 2) ? elem_t'(32512) : elem_t'(-32512);
            end
        end
    endtask

    function automatic row_t pack_row(input bit is_a, input int r);
        row_t row;
        for (int c = 0; c < MAT_DIM; c++) begin
            row[c*DATA_WIDTH +: DATA_WIDTH] = is_a ? a_mat[r][c] : b_mat[r][c];
        end
        return row;
    endfunction

    // C blocks in output order with a floor shift by 8 and a clamp to 16 bits
    task automatic compute_expected();
        block_t blk;
        longint sum;
        longint val;
        for (int bi = 0; bi < BLOCKS_PER_DIM; bi++) begin
            for (int bj = 0; bj < BLOCKS_PER_DIM; bj++) begin
                for (int r = 0; r < BLOCK_SIZE; r++) begin
                    for (int c = 0; c < BLOCK_SIZE; c++) begin
                        sum = 0;
                        for (int m = 0; m < MAT_DIM; m++) begin
                            sum += longint'(a_mat[bi*2+r][m]) * longint'(b_mat[m][bj*2+c]);
                        end
                        val = sum >>> FRAC_WIDTH;
                        if (val > 32767) begin
                            val = 32767;
                        end else if (val < -32768) begin
                            val = -32768;
                        end
                        blk[(r*BLOCK_SIZE+c)*DATA_WIDTH +: DATA_WIDTH] = val[DATA_WIDTH-1:0];
                    end
                end
                exp_q.push_back(blk);
                last_q.push_back((bi == BLOCKS_PER_DIM - 1) && (bj == BLOCKS_PER_DIM - 1));
            end
        end
        refresh_head();
    endtask

    task automatic load_rows(input bit gaps);
        int ia;
        int ib;
        ia = 0;
        ib = 0;
        while (ia < MAT_DIM || ib < MAT_DIM) begin
            a_row_valid = 1'b0;
            b_row_valid = 1'b0;
            if (ia < MAT_DIM && (!gaps || ($urandom % 3) != 0)) begin
                a_row       = pack_row(1'b1, ia);
                a_row_valid = 1'b1;
                ia++;
            end
            if (ib < MAT_DIM && (!gaps || ($urandom % 3) != 0)) begin
                b_row       = pack_row(1'b0, ib);
                b_row_valid = 1'b1;
                ib++;
            end
            next_cycle();
        end
        a_row_valid = 1'b0;
        b_row_valid = 1'b0;
    endtask

    task automatic run_matmul(input bit gaps, input bit extra_start, input int stall);
        stall_pct = stall;
        compute_expected();
        next_cycle();
        started = 1'b1;
        start   = 1'b1;
        next_cycle();
        start = 1'b0;
        if (!busy) begin
            other_errors++;
            $display("busy did not rise after an accepted start at %0t", $time);
        end
        load_rows(gaps);
        while (busy) begin
            // Second start while both converters sit idle behind the last C block
            start = extra_start && c_valid && c_last;
            next_cycle();
        end
        start = 1'b0;
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d C blocks never arrived before busy fell", exp_q.size());
        end
        stall_pct = 0;
    endtask

    // Queue head is consumed on each output transfer
    always @(posedge clk) begin
        if (rst_n && c_valid && c_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            void'(last_q.pop_front());
            blocks_checked++;
            refresh_head();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            other_errors++;
            $display("Timeout after %0d cycles with busy=%0b, run never completed",
                     cycle_cnt, busy);
            report_and_finish();
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (c_valid && c_ready && exp_avail) |-> (c_block == exp_head))
    else begin
        value_errors++;
        $display("FAILED at %0t: c_block expected %h, got %h",
                 $time, $sampled(exp_head), $sampled(c_block));
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (c_valid && c_ready && exp_avail) |-> (c_last == exp_head_last))
    else begin
        value_errors++;
        $display("FAILED at %0t: c_last expected %0b, got %0b",
                 $time, $sampled(exp_head_last), $sampled(c_last));
    end

    assert property (@(posedge clk) disable iff (!rst_n) c_valid |-> exp_avail)
    else begin
        other_errors++;
        $display("Unexpected c_valid at %0t with no C block pending", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (c_valid && !c_ready) |=> (c_valid && $stable(c_block) && $stable(c_last)))
    else begin
        other_errors++;
        $display("Output changed or dropped while c_ready was low at %0t", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(c_valid && c_ready && c_last))
    else begin
        other_errors++;
        $display("busy fell at %0t without a c_last transfer just before", $time);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!c_valid && !c_last && !busy))
    else begin
        other_errors++;
        $display("Outputs active at %0t before the first start", $time);
    end

    initial begin
        start          = 1'b0;
        a_row_valid    = 1'b0;
        a_row          = '0;
        b_row_valid    = 1'b0;
        b_row          = '0;
        c_ready        = 1'b1;
        stall_pct      = 0;
        started        = 1'b0;
        exp_avail      = 1'b0;
        value_errors   = 0;
        other_errors   = 0;
        blocks_checked = 0;
        cycle_cnt      = 0;
        void'($urandom(32'h51ae));
        while (!rst_n) begin
            next_cycle();
        end
        repeat (4) next_cycle();

        // Identity A passes the blocks of B through
        set_identity_a();
        fill_matrix(1'b0, 8191);
        run_matmul(1'b0, 1'b0, 0);

        repeat (4) begin
            fill_matrix(1'b1, 512);
            fill_matrix(1'b0, 512);
            run_matmul(1'b0, 1'b0, 0);
        end

        set_large_operands();
        run_matmul(1'b0, 1'b0, 0);

        // Output back-pressure
        fill_matrix(1'b1, 1024);
        fill_matrix(1'b0, 1024);
        run_matmul(1'b0, 1'b0, 50);

        // Interleaved rows with gaps and a start while busy
        fill_matrix(1'b1, 1024);
        fill_matrix(1'b0, 1024);
        run_matmul(1'b1, 1'b1, 0);

        report_and_finish();
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps
// Testbench clock and reset source
// 100 ns clock, reset held low for the first 5 cycles
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a falling edge like the other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
